// ==== source/ng_pkg.sv ====
package ng_pkg;

	localparam int WORD_W = 16;                    // Machine word width

	typedef logic [WORD_W-1:0] word_t;             // Data word, one's complement
	typedef logic [3:0]        order_t;            // Micro-order code
	typedef logic [1:0]        radr_t;             // Register addr: A, Q, Z, LP

	// Read pulses put a source onto the write bus
	localparam int CP_RA   = 0;                    // Read A
	localparam int CP_RQ   = 1;                    // Read Q
	localparam int CP_RZ   = 2;                    // Read Z
	localparam int CP_RLP  = 3;                    // Read LP
	localparam int CP_RU   = 4;                    // Read adder sum
	localparam int CP_RCH  = 5;                    // Read external input word

	// Write pulses load a register from the write bus
	localparam int CP_WA   = 6;                    // Write A
	localparam int CP_WA0  = 7;                    // Write addressed reg, A
	localparam int CP_WA1  = 8;                    // Write addressed reg, Q
	localparam int CP_WA2  = 9;                    // Write addressed reg, Z
	localparam int CP_WA3  = 10;                   // Write addressed reg, LP
	localparam int CP_WALP = 11;                   // Shift into A and LP13
	localparam int CP_WQ   = 12;                   // Write Q
	localparam int CP_WLP  = 13;                   // Write LP, shifted layout
	localparam int CP_WZ   = 14;                   // Write Z
	localparam int CP_WX   = 15;                   // Write adder X
	localparam int CP_WY   = 16;                   // Write adder Y

	localparam int CP_W    = CP_WY + 1;            // Pulse count, one bit each

	typedef logic [CP_W-1:0] cp_t;                 // Pulse vector, 0 = asserted

	// Order codes, one fixed pulse set each
	localparam order_t OR_NOP  = 4'h0;             // No pulses
	localparam order_t OR_CA   = 4'h1;             // Input to A
	localparam order_t OR_CQ   = 4'h2;             // Input to Q
	localparam order_t OR_CZ   = 4'h3;             // Input to Z
	localparam order_t OR_CLP  = 4'h4;             // Input to LP
	localparam order_t OR_CALP = 4'h5;             // Input shifted into A, LP13
	localparam order_t OR_CX   = 4'h6;             // Input to X
	localparam order_t OR_CY   = 4'h7;             // Input to Y
	localparam order_t OR_CSC  = 4'h8;             // Input to addressed reg
	localparam order_t OR_AX   = 4'h9;             // A to X
	localparam order_t OR_QY   = 4'hA;             // Q to Y
	localparam order_t OR_UA   = 4'hB;             // Sum to A
	localparam order_t OR_UZ   = 4'hC;             // Sum to Z
	localparam order_t OR_ZQ   = 4'hD;             // Z to Q
	localparam order_t OR_LPA  = 4'hE;             // LP to A
	localparam order_t OR_AALP = 4'hF;             // A shifted into A, LP13

endpackage

// ==== source/ng_cpm.sv ====
`timescale 1ns/1ns
module ng_cpm import ng_pkg::*; (
	input  logic   CLK2,                           // Clock pulse 2
	input  logic   GENRST,                         // Sync reset, active low
	input  order_t order,                          // Micro-order code
	input  radr_t  addr,                           // Register address for OR_CSC
	output cp_t    cp                              // Registered pulses, active low
);

	cp_t act;                                      // Decoded pulses, active high

	// Pulse matrix, read half and write half decoded apart
	always_comb begin
		act = '0;                                  // Nothing asserted by default

		case (order)                               // Bus source
			OR_CA, OR_CQ, OR_CZ, OR_CLP,
			OR_CALP, OR_CX, OR_CY, OR_CSC:
				act[CP_RCH] = 1'b1;                // External word
			OR_AX, OR_AALP: act[CP_RA] = 1'b1;     // A
			OR_QY:          act[CP_RQ] = 1'b1;     // Q
			OR_UA, OR_UZ:   act[CP_RU] = 1'b1;     // Adder sum
			OR_ZQ:          act[CP_RZ] = 1'b1;     // Z
			OR_LPA:         act[CP_RLP] = 1'b1;    // LP
			default: ;                             // OR_NOP reads nothing
		endcase

		case (order)                               // Bus destination
			OR_CA, OR_UA, OR_LPA: act[CP_WA] = 1'b1;      // A
			OR_CQ, OR_ZQ:         act[CP_WQ] = 1'b1;      // Q
			OR_CZ, OR_UZ:         act[CP_WZ] = 1'b1;      // Z
			OR_CLP:               act[CP_WLP] = 1'b1;     // LP, shifted
			OR_CALP, OR_AALP:     act[CP_WALP] = 1'b1;    // A right shift, LP13
			OR_CX, OR_AX:         act[CP_WX] = 1'b1;      // X
			OR_CY, OR_QY:         act[CP_WY] = 1'b1;      // Y
			OR_CSC: begin
				case (addr)                        // Addressed write
					2'd0:    act[CP_WA0] = 1'b1;   // A
					2'd1:    act[CP_WA1] = 1'b1;   // Q
					2'd2:    act[CP_WA2] = 1'b1;   // Z
					default: act[CP_WA3] = 1'b1;   // LP
				endcase
			end
			default: ;                             // OR_NOP writes nothing
		endcase
	end

	// Pulses live for one full cycle after the sampling edge
	always_ff @(posedge CLK2) begin
		if (!GENRST) begin
			cp <= '1;                              // All pulses idle
		end else begin
			cp <= ~act;                            // Active low on the matrix
		end
	end

endmodule

// ==== source/ng_crg.sv ====
`timescale 1ns/1ns
module ng_crg import ng_pkg::*; (
	input  logic  CLK2,                            // Clock pulse 2
	input  logic  GENRST,                          // Sync reset, active low
	input  cp_t   cp,                              // Control pulses, active low
	input  word_t write_bus,                       // Write bus
	output word_t a_reg_bus,                       // A register
	output word_t q_reg_bus,                       // Q register
	output word_t z_reg_bus,                       // Z register
	output word_t lp_reg_bus                       // LP register
);

	word_t a;                                      // Accumulator
	word_t q;                                      // Return address / quotient
	word_t z;                                      // Program counter
	word_t lp;                                     // Lower product

	logic  wr_a;                                   // Plain A load
	logic  wr_alp;                                 // A shift plus LP13
	logic  wr_q;                                   // Q load
	logic  wr_z;                                   // Z load
	logic  wr_lp;                                  // LP shifted load

	// Direct and addressed pulses share each register's path
	assign wr_a   = !cp[CP_WA] || !cp[CP_WA0];
	assign wr_alp = !cp[CP_WALP];
	assign wr_q   = !cp[CP_WQ] || !cp[CP_WA1];
	assign wr_z   = !cp[CP_WZ] || !cp[CP_WA2];
	assign wr_lp  = !cp[CP_WLP] || !cp[CP_WA3];

	assign a_reg_bus  = a;
	assign q_reg_bus  = q;
	assign z_reg_bus  = z;
	assign lp_reg_bus = lp;

	always_ff @(posedge CLK2) begin
		if (!GENRST) begin
			a <= '0;
			q <= '0;
			z <= '0;
		end else begin
			if (wr_a) begin
				a <= write_bus;                    // Straight copy
			end else if (wr_alp) begin
				a <= {write_bus[15], write_bus[15:1]};    // Sign kept, shifted right
			end
			if (wr_q) begin
				q <= write_bus;
			end
			if (wr_z) begin
				z <= write_bus;
			end
		end
	end

	// LP13 has its own source, so it is kept out of the main load
	always_ff @(posedge CLK2) begin
		if (!GENRST) begin
			lp <= '0;
		end else if (wr_lp) begin
			lp[15:14] <= {2{write_bus[0]}};        // Bus LSB into both top bits
			lp[13]    <= 1'b0;                     // Cleared on a plain LP write
			lp[12:0]  <= write_bus[13:1];          // Shifted down by one
		end else if (wr_alp) begin
			lp[13]    <= write_bus[0];             // Bit shifted out of A
		end
	end

endmodule

// ==== source/ng_adr.sv ====
`timescale 1ns/1ns
module ng_adr import ng_pkg::*; (
	input  logic  CLK2,                            // Clock pulse 2
	input  logic  GENRST,                          // Sync reset, active low
	input  cp_t   cp,                              // Control pulses, active low
	input  word_t write_bus,                       // Write bus
	output word_t u_bus                            // One's-complement sum X + Y
);

	word_t         x;                              // Adder input X
	word_t         y;                              // Adder input Y
	logic [WORD_W:0] raw_sum;                      // Sum with carry out of bit 15

	always_ff @(posedge CLK2) begin
		if (!GENRST) begin
			x <= '0;
			y <= '0;
		end else begin
			if (!cp[CP_WX]) begin
				x <= write_bus;
			end
			if (!cp[CP_WY]) begin
				y <= write_bus;
			end
		end
	end

	// Plain binary add, top bit is the carry
	assign raw_sum = {1'b0, x} + {1'b0, y};

	// End-around carry folds back into bit 0
	// A second carry cannot occur: the largest raw sum leaves 0xFFFE below the carry
	assign u_bus = raw_sum[WORD_W-1:0] + word_t'(raw_sum[WORD_W]);

endmodule

// ==== source/ng_wbus.sv ====
`timescale 1ns/1ns
module ng_wbus import ng_pkg::*; (
	input  cp_t   cp,                              // Control pulses, active low
	input  word_t a_reg_bus,                       // A register
	input  word_t q_reg_bus,                       // Q register
	input  word_t z_reg_bus,                       // Z register
	input  word_t lp_reg_bus,                      // LP register
	input  word_t u_bus,                           // Adder sum
	input  word_t in_word,                         // External input word
	output word_t write_bus                        // Combined bus
);

	word_t a_g;                                    // A when RA asserted
	word_t q_g;                                    // Q when RQ asserted
	word_t z_g;                                    // Z when RZ asserted
	word_t lp_g;                                   // LP when RLP asserted
	word_t u_g;                                    // Sum when RU asserted
	word_t ch_g;                                   // Input when RCH asserted

	// Each source masked by its own read pulse
	assign a_g  = a_reg_bus  & {WORD_W{!cp[CP_RA]}};
	assign q_g  = q_reg_bus  & {WORD_W{!cp[CP_RQ]}};
	assign z_g  = z_reg_bus  & {WORD_W{!cp[CP_RZ]}};
	assign lp_g = lp_reg_bus & {WORD_W{!cp[CP_RLP]}};
	assign u_g  = u_bus      & {WORD_W{!cp[CP_RU]}};
	assign ch_g = in_word    & {WORD_W{!cp[CP_RCH]}};

	// Wired OR, idle bus reads zero
	assign write_bus = a_g | q_g | z_g | lp_g | u_g | ch_g;

endmodule

// ==== source/ng_dp.sv ====
`timescale 1ns/1ns
module ng_dp import ng_pkg::*; (
	input  logic   CLK2,                           // Clock pulse 2
	input  logic   GENRST,                         // Sync reset, active low
	input  order_t order,                          // Micro-order code
	input  radr_t  addr,                           // Register address
	input  word_t  in_word,                        // External input, one cycle late
	output word_t  a_reg,                          // A register
	output word_t  q_reg,                          // Q register
	output word_t  z_reg,                          // Z register
	output word_t  lp_reg,                         // LP register
	output word_t  write_bus                       // Write bus
);

	cp_t   cp;                                     // Registered control pulses
	word_t u_bus;                                  // Adder sum

	ng_cpm i_cpm (
		.CLK2       (CLK2),
		.GENRST     (GENRST),
		.order      (order),
		.addr       (addr),
		.cp         (cp)
	);

	ng_crg i_crg (
		.CLK2       (CLK2),
		.GENRST     (GENRST),
		.cp         (cp),
		.write_bus  (write_bus),
		.a_reg_bus  (a_reg),
		.q_reg_bus  (q_reg),
		.z_reg_bus  (z_reg),
		.lp_reg_bus (lp_reg)
	);

	ng_adr i_adr (
		.CLK2       (CLK2),
		.GENRST     (GENRST),
		.cp         (cp),
		.write_bus  (write_bus),
		.u_bus      (u_bus)
	);

	ng_wbus i_wbus (
		.cp         (cp),
		.a_reg_bus  (a_reg),
		.q_reg_bus  (q_reg),
		.z_reg_bus  (z_reg),
		.lp_reg_bus (lp_reg),
		.u_bus      (u_bus),
		.in_word    (in_word),
		.write_bus  (write_bus)
	);

endmodule

// ==== dv/ng_dp_clkgen.sv ====
`timescale 1ns/1ns
module ng_dp_clkgen (
	output logic CLK2,                             // 8 ns clock
	output logic GENRST                            // Sync reset, active low
);

	localparam int HALF_NS = 4;                    // Half of the 8 ns period
	localparam int RST_CYC = 5;                    // Rising edges held in reset

	initial begin
		CLK2 = 1'b0;
		forever #HALF_NS CLK2 = ~CLK2;             // First rising edge at 4 ns
	end

	initial begin
		GENRST = 1'b0;                             // Low from time zero
		repeat (RST_CYC) @(posedge CLK2);
		@(negedge CLK2);
		GENRST = 1'b1;                             // Released on a falling edge
	end

endmodule

// ==== dv/tb_ng_dp.sv ====
`timescale 1ns/1ns
module tb_ng_dp import ng_pkg::*; ();

	localparam int NUM_VEC  = 37;                  // Lines in the vector file
	localparam int VEC_COLS = 7;                   // Words per line
	localparam int CLK_NS   = 8;                   // Clock period
	localparam int WDOG_NS  = (NUM_VEC + 10) * CLK_NS;    // Hang limit

	logic   CLK2;                                  // From clock generator
	logic   GENRST;                                // From clock generator
	order_t order;                                 // Driven on falling edge
	radr_t  addr;                                  // Driven with order
	word_t  in_word;                               // One line behind order
	word_t  a_reg;
	word_t  q_reg;
	word_t  z_reg;
	word_t  lp_reg;
	word_t  write_bus;

	logic [15:0] vec_mem [0:NUM_VEC*VEC_COLS-1];   // Flat copy of the vector file
	int          errors;                           // Failed checks
	int          checks;                           // Checks done

	ng_dp_clkgen i_clkgen (
		.CLK2      (CLK2),
		.GENRST    (GENRST)
	);

	ng_dp i_dut (
		.CLK2      (CLK2),
		.GENRST    (GENRST),
		.order     (order),
		.addr      (addr),
		.in_word   (in_word),
		.a_reg     (a_reg),
		.q_reg     (q_reg),
		.z_reg     (z_reg),
		.lp_reg    (lp_reg),
		.write_bus (write_bus)
	);

	// One word compare with report on mismatch
	task automatic check_word(input string what, input string name,
		input word_t exp_val, input word_t act_val);
		checks++;
		assert (act_val === exp_val) else begin
			errors++;
			$display("Fail at %0t ns: %s expected %h got %h (%s)",
				$time, name, exp_val, act_val, what);
		end
	endtask

	// Expected registers of one vector line
	task automatic check_line(input int n);
		int    base;
		string what;
		base = n * VEC_COLS;
		what = $sformatf("vector %0d", n + 1);     // Vector numbers count from 1
		check_word(what, "a_reg", vec_mem[base + 3], a_reg);
		check_word(what, "q_reg", vec_mem[base + 4], q_reg);
		check_word(what, "z_reg", vec_mem[base + 5], z_reg);
		check_word(what, "lp_reg", vec_mem[base + 6], lp_reg);
	endtask

	// Bus value while one line's order is live, from the pulse table
	function automatic word_t bus_expect(input int m);
		int     base;
		word_t  a_pre;
		word_t  q_pre;
		word_t  z_pre;
		word_t  lp_pre;
		order_t ord;
		word_t  exp_bus;
		base = m * VEC_COLS;
		if (m == 0) begin
			a_pre  = '0;                           // Registers still cleared
			q_pre  = '0;
			z_pre  = '0;
			lp_pre = '0;
		end else begin
			a_pre  = vec_mem[base - VEC_COLS + 3];    // Result of the line before
			q_pre  = vec_mem[base - VEC_COLS + 4];
			z_pre  = vec_mem[base - VEC_COLS + 5];
			lp_pre = vec_mem[base - VEC_COLS + 6];
		end
		ord = vec_mem[base][3:0];
		case (ord)
			OR_CA, OR_CQ, OR_CZ, OR_CLP,
			OR_CALP, OR_CX, OR_CY, OR_CSC:
				exp_bus = vec_mem[base + 2];       // Input word
			OR_AX, OR_AALP: exp_bus = a_pre;
			OR_QY:          exp_bus = q_pre;
			OR_ZQ:          exp_bus = z_pre;
			OR_LPA:         exp_bus = lp_pre;
			OR_UA:          exp_bus = vec_mem[base + 3];    // Sum lands in A
			OR_UZ:          exp_bus = vec_mem[base + 5];    // Sum lands in Z
			default:        exp_bus = '0;          // Nothing read
		endcase
		return exp_bus;
	endfunction

	initial begin
		errors  = 0;
		checks  = 0;
		order   = OR_NOP;                          // Idle while in reset
		addr    = '0;
		in_word = '0;
		$readmemh("dv/ng_dp_vectors.txt", vec_mem);

		wait (GENRST === 1'b1);
		check_word("reset", "a_reg", '0, a_reg);    // Cleared state
		check_word("reset", "q_reg", '0, q_reg);
		check_word("reset", "z_reg", '0, z_reg);
		check_word("reset", "lp_reg", '0, lp_reg);
		check_word("reset", "write_bus", '0, write_bus);    // No read pulse live

		// Order n, input word n-1, result of n-2 visible
		for (int n = 0; n < NUM_VEC + 2; n++) begin
			@(negedge CLK2);
			if (n >= 2) begin
				check_line(n - 2);
			end
			if (n < NUM_VEC) begin
				order = vec_mem[n * VEC_COLS][3:0];
				addr  = vec_mem[n * VEC_COLS + 1][1:0];
			end else begin
				order = OR_NOP;                    // Drain the pipeline
				addr  = '0;
			end
			if (n >= 1 && n <= NUM_VEC) begin
				in_word = vec_mem[(n - 1) * VEC_COLS + 2];
			end else begin
				in_word = '0;
			end
			if (n >= 1 && n <= NUM_VEC) begin
				#(CLK_NS / 4);                     // Bus settled before the rising edge
				check_word($sformatf("vector %0d", n), "write_bus",
					bus_expect(n - 1), write_bus);
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#(WDOG_NS);
		$display("Watchdog: vectors did not finish within %0d ns", WDOG_NS);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== ng_dp.f ====
source/ng_pkg.sv
source/ng_cpm.sv
source/ng_crg.sv
source/ng_adr.sv
source/ng_wbus.sv
source/ng_dp.sv
dv/ng_dp_clkgen.sv
dv/tb_ng_dp.sv

// ==== run_ng_dp.sh ====
#!/bin/sh
# Compile with Verilator, run from the project root, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ng_dp -f ng_dp.f -o sim_ng_dp \
	|| { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/sim_ng_dp)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TB PASSED" \
	&& echo "Simulation run passed" \
	|| { echo "Simulation run failed"; exit 1; }

// ==== dv/ng_dp_vectors.txt ====
// order addr in_word | expected a_reg q_reg z_reg lp_reg after the order, all hex
// in_word is consumed in the cycle after its order is sampled
0 0 0000 0000 0000 0000 0000
1 0 1234 1234 0000 0000 0000
2 0 5678 1234 5678 0000 0000
3 0 9ABC 1234 5678 9ABC 0000
0 0 FFFF 1234 5678 9ABC 0000
8 0 1111 1111 5678 9ABC 0000
8 1 2222 1111 2222 9ABC 0000
8 2 3333 1111 2222 3333 0000
8 3 2005 1111 2222 3333 D002
5 0 8003 C001 2222 3333 F002
4 0 0006 C001 2222 3333 0003
F 0 0000 E000 2222 3333 2003
4 0 0001 E000 2222 3333 C000
F 0 0000 F000 2222 3333 C000
6 0 8001 F000 2222 3333 C000
7 0 8001 F000 2222 3333 C000
B 0 0000 0003 2222 3333 C000
6 0 7FFF 0003 2222 3333 C000
7 0 8000 0003 2222 3333 C000
B 0 0000 FFFF 2222 3333 C000
6 0 1234 FFFF 2222 3333 C000
7 0 4321 FFFF 2222 3333 C000
C 0 0000 FFFF 2222 5555 C000
D 0 0000 FFFF 5555 5555 C000
E 0 0000 C000 5555 5555 C000
9 0 0000 C000 5555 5555 C000
A 0 0000 C000 5555 5555 C000
C 0 0000 C000 5555 1556 C000
B 0 0000 1556 5555 1556 C000
9 0 0000 1556 5555 1556 C000
C 0 0000 1556 5555 6AAB C000
8 3 FFFF 1556 5555 6AAB DFFF
E 0 0000 DFFF 5555 6AAB DFFF
F 0 0000 EFFF 5555 6AAB FFFF
0 0 FFFF EFFF 5555 6AAB FFFF
1 0 0F0F 0F0F 5555 6AAB FFFF
0 0 0000 0F0F 5555 6AAB FFFF
